// ==== list.f ====
src/fma_pkg.sv
src/booth_csa_multiplier.sv
src/fma_unpack.sv
src/fma_multiply_align.sv
src/fma_add_normalize.sv
src/fma_round_pack.sv
src/fma_top.sv
testbench/fma_tb_clock.sv
testbench/fma_asserts.sv
testbench/fma_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the FMA testbench

VERILATOR ?= verilator
TOP       ?= fma_tb
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/fma_tb.sv ====
// FMA testbench with directed test tasks, result checks, LFSR operands and timeout
`timescale 1ns/1ps

module fma_tb import fma_pkg::*; ();

   localparam int reset_cycles  = 5;
   localparam int idle_cycles   = 8;
   localparam int n_integer     = 20;
   localparam int n_cancel      = 8;
   localparam int n_burst       = 10;
   // a single item costs its drive cycle plus the 5 cycle latency
   localparam int test_cycles   = reset_cycles + 1 + idle_cycles
                                  + (n_integer + n_cancel + 3) * 6 + n_burst + 6;
   localparam int timeout_limit = 2 * test_cycles;

   logic        clk;
   logic        rst_n;
   logic        in_valid;
   fp32_t       a, b, c;
   logic        out_valid;
   fp32_t       result;
   logic [15:0] lfsr_state;
   int          cycle_count = 0;
   logic        run_finished = 1'b0;

   fma_tb_clock clock_inst (
      .clk (clk)
   );

   fma_top fma_top_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .a         (a),
      .b         (b),
      .c         (c),
      .out_valid (out_valid),
      .result    (result)
   );

   task automatic stop_with_failure();
      run_finished = 1'b1;
      $display("Checks failed");
      $fatal(1, "stopping at the first failure");
   endtask

   task automatic report_error(input string msg);
      $display("CHECK FAILED at %0d ns: %s", $time, msg);
      stop_with_failure();
   endtask

   // 16-bit Galois LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output int value);
      value = 0;
      for (int i = 0; i < n; i++) begin
         value = (value << 1) | int'(lfsr_state[0]);
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // nonzero integer of magnitude 1 .. 2^mag_bits with a random sign
   task automatic random_operand(input int mag_bits, output int v);
      int m;
      int s;
      take_bits(mag_bits, m);
      take_bits(1, s);
      v = (s != 0) ? -(m + 1) : m + 1;
   endtask

   function automatic real pow2(int n);
      real r;
      r = 1.0;
      for (int i = 0; i < ((n < 0) ? -n : n); i++)
         r = (n < 0) ? r / 2.0 : r * 2.0;
      return r;
   endfunction

   // double to binary32 rounded to nearest even in the normal range
   function automatic fp32_t to_fp32(real r);
      logic [63:0] d;
      logic [10:0] dexp;
      logic [22:0] man;
      logic        guard;
      logic        sticky;
      logic [23:0] man_r;
      logic [8:0]  e;
      d = $realtobits(r);
      dexp = d[62:52];
      if (dexp == '0)
         return {d[63], 31'b0};
      man = d[51:29];
      guard = d[28];
      sticky = |d[27:0];
      man_r = {1'b0, man} + 24'(guard & (sticky | man[0]));
      e = 9'(dexp - 11'd896);
      e = e + 9'(man_r[23]);
      return {d[63], e[7:0], man_r[22:0]};
   endfunction

   task automatic expect_idle(input string what);
      assert (out_valid === 1'b0)
         else report_error($sformatf("%s: out_valid high with no item due", what));
   endtask

   task automatic expect_result(input fp32_t expected, input string what);
      assert (out_valid === 1'b1)
         else report_error($sformatf("%s: out_valid low when the result was due", what));
      assert (result === expected)
         else report_error($sformatf("%s: result %h, expected %h", what, result, expected));
   endtask

   // one item into an empty pipeline with out_valid watched over the whole latency
   task automatic run_single(input fp32_t op_a, input fp32_t op_b, input fp32_t op_c,
                             input fp32_t expected, input string what);
      @(negedge clk);
      in_valid = 1'b1;
      a = op_a;
      b = op_b;
      c = op_c;
      for (int i = 1; i <= 4; i++) begin
         @(negedge clk);
         if (i == 1)
            in_valid = 1'b0;
         expect_idle(what);
      end
      @(negedge clk);
      expect_result(expected, what);
   endtask

   task automatic run_integer(input int ia, input int ib, input int ic);
      run_single(to_fp32(real'(ia)), to_fp32(real'(ib)), to_fp32(real'(ic)),
                 to_fp32(real'(ia) * real'(ib) + real'(ic)),
                 $sformatf("%0d * %0d + %0d", ia, ib, ic));
   endtask

   task automatic idle_after_reset();
      for (int i = 0; i < idle_cycles; i++) begin
         @(negedge clk);
         expect_idle("idle after reset");
      end
   endtask

   task automatic integer_products();
      int ia, ib, ic;
      for (int k = 0; k < n_integer; k++) begin
         random_operand(10, ia);
         random_operand(10, ib);
         random_operand(10, ic);
         run_integer(ia, ib, ic);
      end
   endtask

   // c close to -a*b so the sum collapses to a few units or zero
   task automatic cancellation_to_small();
      int ia, ib, d, s;
      for (int k = 0; k < n_cancel; k++) begin
         take_bits(5, ia);
         take_bits(1, s);
         ia = (s != 0) ? -(ia % 31 + 1) : ia % 31 + 1;
         take_bits(5, ib);
         ib = ib % 31 + 1;
         take_bits(3, d);
         run_integer(ia, ib, -(ia * ib) + d - 4);
      end
   endtask

   task automatic rounding_to_even();
      real one_plus;
      one_plus = 1.0 + pow2(-23);
      // the 2^-46 term lies below the last place and drops
      run_single(to_fp32(one_plus), to_fp32(one_plus), 32'h0,
                 to_fp32(one_plus * one_plus), "square of 1+2^-23");
      // 1.75 + 2^-23 + 2^-24 is a tie with an odd last bit
      run_single(to_fp32(one_plus), to_fp32(1.5), to_fp32(0.25),
                 to_fp32(one_plus * 1.5 + 0.25), "tie with odd last bit");
   endtask

   task automatic addend_dominance();
      real big;
      big = pow2(60);
      run_single(to_fp32(1.0), to_fp32(1.0), to_fp32(big),
                 to_fp32(1.0 * 1.0 + big), "addend 2^60 dominates");
   endtask

   task automatic back_to_back_burst();
      fp32_t op_a [n_burst];
      fp32_t op_b [n_burst];
      fp32_t op_c [n_burst];
      fp32_t expected [n_burst];
      int    ia, ib, ic;
      for (int k = 0; k < n_burst; k++) begin
         random_operand(10, ia);
         random_operand(10, ib);
         random_operand(10, ic);
         op_a[k] = to_fp32(real'(ia));
         op_b[k] = to_fp32(real'(ib));
         op_c[k] = to_fp32(real'(ic));
         expected[k] = to_fp32(real'(ia) * real'(ib) + real'(ic));
      end
      // item k enters at falling edge k and is due at falling edge k+5
      for (int t = 0; t <= n_burst + 5; t++) begin
         @(negedge clk);
         if (t < n_burst) begin
            in_valid = 1'b1;
            a = op_a[t];
            b = op_b[t];
            c = op_c[t];
         end else begin
            in_valid = 1'b0;
         end
         if (t >= 5 && t < n_burst + 5)
            expect_result(expected[t - 5], $sformatf("burst item %0d", t - 5));
         else
            expect_idle("burst edges");
      end
   endtask

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > timeout_limit) begin
         $display("simulation timed out after %0d cycles", timeout_limit);
         stop_with_failure();
      end
   end

   initial begin
      rst_n = 1'b0;
      in_valid = 1'b0;
      a = '0;
      b = '0;
      c = '0;
      lfsr_state = 16'd58260;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      expect_idle("end of reset");
      rst_n = 1'b1;

      idle_after_reset();
      integer_products();
      cancellation_to_small();
      rounding_to_even();
      addend_dominance();
      back_to_back_burst();

      run_finished = 1'b1;
      $display("All checks passed");
      $finish;
   end

   // run ended before the last test completed
   final begin
      if (!run_finished)
         $display("Checks failed");
   end

endmodule

// ==== testbench/fma_asserts.sv ====
// concurrent checks on the FMA valid pipeline, reset and result, with bind to fma_top
`timescale 1ns/1ps

module fma_asserts import fma_pkg::*; (
   input logic  clk,
   input logic  rst_n,
   input logic  in_valid,
   input logic  out_valid,
   input fp32_t result
);

   // a reset edge clears the whole valid pipeline
   property reset_clears_valid;
      @(posedge clk) !rst_n |=> !out_valid;
   endproperty

   // fixed latency of five stage registers
   property valid_latency;
      @(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid, 5);
   endproperty

   property result_known;
      @(posedge clk) out_valid |-> !$isunknown(result);
   endproperty

   reset_clears_valid_check: assert property (reset_clears_valid)
      else $error("out_valid high after a reset edge");
   valid_latency_check: assert property (valid_latency)
      else $error("out_valid does not follow in_valid by 5 cycles");
   result_known_check: assert property (result_known)
      else $error("result has unknown bits while out_valid is high");

endmodule

bind fma_top fma_asserts asserts_inst (
   .clk       (clk),
   .rst_n     (rst_n),
   .in_valid  (in_valid),
   .out_valid (out_valid),
   .result    (result)
);

// ==== testbench/fma_tb_clock.sv ====
// free-running testbench clock with a 100 ns period
`timescale 1ns/1ps

module fma_tb_clock (
   output logic clk
);

   initial clk = 1'b0;

   // half period of 50 ns
   always #50 clk = ~clk;

endmodule

// ==== src/fma_top.sv ====
// pipelined binary32 fused multiply-add top with valid pipeline
`timescale 1ns/1ps

module fma_top import fma_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  in_valid,
   input  fp32_t a,
   input  fp32_t b,
   input  fp32_t c,
   output logic  out_valid,
   output fp32_t result
);

   unpack_s    unpack_q;
   mult_s      mult_q;
   norm_s      norm_q;
   logic [4:0] valid_sr;

   fma_unpack unpack_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .a     (a),
      .b     (b),
      .c     (c),
      .stage (unpack_q)
   );

   fma_multiply_align mult_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .stage_in  (unpack_q),
      .stage_out (mult_q)
   );

   fma_add_normalize add_norm_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .stage_in  (mult_q),
      .stage_out (norm_q)
   );

   fma_round_pack round_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .stage_in (norm_q),
      .result   (result)
   );

   // one bit per stage register
   always_ff @(posedge clk) begin
      if (!rst_n)
         valid_sr <= '0;
      else
         valid_sr <= {valid_sr[3:0], in_valid};
   end

   assign out_valid = valid_sr[4];

endmodule

// ==== src/fma_round_pack.sv ====
// stage 5: second normalization, round to nearest even, exponent and packing
`timescale 1ns/1ps

module fma_round_pack import fma_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  norm_s stage_in,
   output fp32_t result
);

   lz_t     lz;
   sshift_t lz_bound, real_shift;
   norm_t   final_window;
   mant_t   man, man_rounded;
   logic    guard, round_bit, sticky, round_up, exp_bump;
   exp_t    final_exp;
   fp32_t   result_d;

   always_comb begin
      lz = lz_count(stage_in.window);
      lz_bound = $signed({2'b0, lz}) + sshift_t'(round_window_offset);

      if (stage_in.shift_left[8])
         real_shift = '0;
      else if (lz_bound > stage_in.shift_left)
         real_shift = stage_in.shift_left;
      else
         real_shift = $signed({2'b0, lz});
      final_window = stage_in.window << real_shift;

      man = final_window[37:14];
      // product only contributes sticky weight in concat
      guard = (stage_in.mode == mode_add) ? final_window[13] : 1'b0;
      round_bit = (stage_in.mode == mode_add) ? final_window[12] : 1'b0;
      sticky = (stage_in.mode == mode_add) ? |final_window[11:0] : 1'b0;

      // ties go to the even mantissa
      round_up = guard & (round_bit | sticky | man[0]);
      {exp_bump, man_rounded} = {1'b0, man} + 25'(round_up);

      if (stage_in.mode == mode_concat && stage_in.dir == align_left)
         final_exp = stage_in.exp_c + exp_t'(exp_bump);
      else
         final_exp = stage_in.current_exp + exp_t'(norm_offset)
                     - stage_in.real_shift[7:0] - real_shift[7:0] + exp_t'(exp_bump);

      // exact cancellation gives +0
      if (man == '0 && !exp_bump)
         result_d = '0;
      else
         result_d = {stage_in.sign, final_exp, man_rounded[22:0]};
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         result <= '0;
      else
         result <= result_d;
   end

endmodule

// ==== src/fma_add_normalize.sv ====
// stages 3 and 4: split signed addition, magnitude, sign and first normalization
`timescale 1ns/1ps

module fma_add_normalize import fma_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  mult_s stage_in,
   output norm_s stage_out
);

   sum_t        addend_ext;
   logic [40:0] low_sum;
   add_s        add_d, add_q;

   logic [35:0] high_sum;
   sum_t        raw_sum, mag_sum, shifted;
   logic        sum_neg;
   lz_t         lz;
   sshift_t     shift_left;
   norm_s       norm_d;

   // first half, low 40 bits with carry out
   always_comb begin
      // subtract as invert plus carry in
      addend_ext = stage_in.sign_eff_c ? {1'b1, ~stage_in.addend} : {1'b0, stage_in.addend};
      low_sum = {1'b0, stage_in.product[39:0]} + {1'b0, addend_ext[39:0]}
                + 41'(stage_in.sign_eff_c);

      add_d.sum_lo = low_sum[39:0];
      add_d.carry = low_sum[40];
      add_d.prod_hi = stage_in.product[47:40];
      add_d.addend_hi = addend_ext[75:40];
      add_d.mode = stage_in.mode;
      add_d.dir = stage_in.dir;
      add_d.current_exp = stage_in.current_exp;
      add_d.exp_c = stage_in.exp_c;
      add_d.sign_ab = stage_in.sign_ab;
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         add_q <= '0;
      else
         add_q <= add_d;
   end

   // second half
   always_comb begin
      high_sum = {28'b0, add_q.prod_hi} + add_q.addend_hi + 36'(add_q.carry);
      raw_sum = {high_sum, add_q.sum_lo};
      sum_neg = raw_sum[75];
      mag_sum = sum_neg ? (~raw_sum + 76'd1) : raw_sum;

      lz = lz_count(mag_sum[75:38]);
      // exponent if normalized fully by lz
      shift_left = $signed({1'b0, add_q.current_exp})
                   - ($signed({2'b0, lz}) - sshift_t'(norm_offset));

      norm_d.shift_left = shift_left;
      // subnormals stay subnormal
      norm_d.real_shift = !shift_left[8] ? $signed({2'b0, lz})
                                          : $signed({1'b0, add_q.current_exp});
      shifted = mag_sum << norm_d.real_shift;

      norm_d.window = shifted[75:38];
      norm_d.current_exp = add_q.current_exp;
      norm_d.exp_c = add_q.exp_c;
      norm_d.sign = add_q.sign_ab ^ sum_neg;
      norm_d.mode = add_q.mode;
      norm_d.dir = add_q.dir;
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         stage_out <= '0;
      else
         stage_out <= norm_d;
   end

endmodule

// ==== src/fma_multiply_align.sv ====
// stage 2: mantissa product and addend alignment with mode selection
`timescale 1ns/1ps

module fma_multiply_align import fma_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  unpack_s stage_in,
   output mult_s   stage_out
);

   prod_t       product;
   ext_addend_t ext_c;
   mult_s       stage_d;

   booth_csa_multiplier mult_inst (
      .mcand   (stage_in.man_a),
      .mplier  (stage_in.man_b),
      .product (product)
   );

   always_comb begin
      // c lines up with product bit 46 when the exponents match
      ext_c = {28'b0, stage_in.man_c, 23'b0};

      stage_d.product = product;
      stage_d.dir = stage_in.dir;
      stage_d.current_exp = stage_in.current_exp;
      stage_d.exp_c = stage_in.exp_c;
      stage_d.sign_ab = stage_in.sign_ab;
      stage_d.sign_eff_c = stage_in.sign_eff_c;

      if (stage_in.dir == align_right) begin
         stage_d.mode = (stage_in.shift > shift_t'(right_far_limit)) ? mode_concat : mode_add;
         stage_d.addend = ext_c >> stage_in.shift;
      end else if (stage_in.shift > shift_t'(left_far_limit)) begin
         // addend far above the product, pin it at the top
         stage_d.mode = mode_concat;
         stage_d.addend = {1'b0, stage_in.man_c, 50'b0};
      end else begin
         stage_d.mode = mode_add;
         stage_d.addend = ext_c << stage_in.shift;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         stage_out <= '0;
      else
         stage_out <= stage_d;
   end

endmodule

// ==== src/fma_unpack.sv ====
// stage 1: operand unpacking, product exponent and alignment decision
`timescale 1ns/1ps

module fma_unpack import fma_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  fp32_t   a,
   input  fp32_t   b,
   input  fp32_t   c,
   output unpack_s stage
);

   logic signed [9:0] true_a, true_b, true_c;
   logic signed [9:0] true_ab, prod_biased, diff, abs_diff;
   unpack_s           stage_d;

   // zero exponent behaves as the smallest normal exponent
   function automatic logic signed [9:0] true_exp(exp_t e);
      return (e == '0) ? 10'(exp_min_true) : $signed({2'b0, e}) - 10'(exp_bias);
   endfunction

   // hidden bit only for normal numbers
   function automatic mant_t split_man(fp32_t x);
      return {(x[30:23] != '0), x[22:0]};
   endfunction

   always_comb begin
      true_a = true_exp(a[30:23]);
      true_b = true_exp(b[30:23]);
      true_c = true_exp(c[30:23]);
      true_ab = true_a + true_b;
      prod_biased = true_ab + 10'(exp_bias);
      diff = true_c - true_ab;
      abs_diff = diff[9] ? -diff : diff;

      stage_d.man_a = split_man(a);
      stage_d.man_b = split_man(b);
      stage_d.man_c = split_man(c);
      stage_d.exp_c = c[30:23];
      if (true_ab == 10'(exp_min_true) || prod_biased[9])
         stage_d.current_exp = '0;
      else if (prod_biased > 10'sd255)
         stage_d.current_exp = 8'hff;
      else
         stage_d.current_exp = prod_biased[7:0];
      // saturate, anything this far is concat mode anyway
      stage_d.shift = (abs_diff > 10'sd255) ? 8'hff : abs_diff[7:0];
      stage_d.dir = diff[9] ? align_right : align_left;
      stage_d.sign_ab = a[31] ^ b[31];
      stage_d.sign_eff_c = a[31] ^ b[31] ^ c[31];
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         stage <= '0;
      else
         stage <= stage_d;
   end

endmodule

// ==== src/booth_csa_multiplier.sv ====
// radix-4 Booth partial products with carry-save reduction to a 48-bit product
`timescale 1ns/1ps

module booth_csa_multiplier import fma_pkg::*; (
   input  mant_t mcand,
   input  mant_t mplier,
   output prod_t product
);

   logic [26:0] mplier_ext;
   logic [49:0] one, two;
   logic [49:0] pp [13];
   logic [49:0] l1 [8];
   logic [49:0] l2 [4];
   logic [49:0] l3 [4];
   logic [49:0] l4 [2];
   logic [49:0] l5 [2];
   logic [49:0] last_s, last_c, full_sum;

   // 3:2 compressor over the full width
   function automatic void csa(input logic [49:0] x, input logic [49:0] y,
                               input logic [49:0] z, output logic [49:0] s,
                               output logic [49:0] c);
      s = x ^ y ^ z;
      c = ((x & y) | (y & z) | (z & x)) << 1;
   endfunction

   always_comb begin
      mplier_ext = {2'b0, mplier, 1'b0};
      one = {26'b0, mcand};
      two = {25'b0, mcand, 1'b0};

      // digit i looks at multiplier bits 2i+1 .. 2i-1
      for (int i = 0; i < 13; i++) begin
         case (mplier_ext[2*i +: 3])
            3'b001, 3'b010: pp[i] = one << (2 * i);
            3'b011:         pp[i] = two << (2 * i);
            3'b100:         pp[i] = (~two + 50'd1) << (2 * i);
            3'b101, 3'b110: pp[i] = (~one + 50'd1) << (2 * i);
            default:        pp[i] = '0;
         endcase
      end

      // level 1
      csa(pp[0], pp[1], pp[2], l1[0], l1[1]);
      csa(pp[3], pp[4], pp[5], l1[2], l1[3]);
      csa(pp[6], pp[7], pp[8], l1[4], l1[5]);
      csa(pp[9], pp[10], pp[11], l1[6], l1[7]);
      // level 2
      csa(l1[0], l1[1], l1[2], l2[0], l2[1]);
      csa(l1[3], l1[4], l1[5], l2[2], l2[3]);
      // level 3
      csa(l2[0], l2[1], l2[2], l3[0], l3[1]);
      csa(l2[3], l1[6], l1[7], l3[2], l3[3]);
      // level 4
      csa(l3[0], l3[1], l3[2], l4[0], l4[1]);
      // level 5
      csa(l4[0], l4[1], l3[3], l5[0], l5[1]);
      // top digit joins last
      csa(l5[0], l5[1], pp[12], last_s, last_c);

      full_sum = last_s + last_c;
      product = full_sum[47:0];
   end

endmodule

// ==== src/fma_pkg.sv ====
// binary32 FMA widths, constants, stage structs and leading-zero count
package fma_pkg;

   typedef logic [31:0] fp32_t;
   typedef logic [7:0] exp_t;
   typedef logic [23:0] mant_t;
   typedef logic [7:0] shift_t;
   typedef logic [47:0] prod_t;
   typedef logic [74:0] ext_addend_t;
   typedef logic [75:0] sum_t;
   typedef logic [37:0] norm_t;
   typedef logic [6:0] lz_t;
   typedef logic signed [8:0] sshift_t;

   // direction the addend moves relative to the product
   typedef enum logic {align_left = 1'b0, align_right = 1'b1} align_dir_e;

   // concat: addend dominates, product only adds sticky weight
   typedef enum logic {mode_concat = 1'b0, mode_add = 1'b1} add_mode_e;

   localparam int exp_bias            = 127;
   localparam int exp_min_true        = -126;
   localparam int right_far_limit     = 47;
   localparam int left_far_limit      = 28;
   localparam int norm_offset         = 29;
   localparam int round_window_offset = 8;

   typedef struct packed {
      mant_t      man_a;
      mant_t      man_b;
      mant_t      man_c;
      exp_t       current_exp;
      exp_t       exp_c;
      shift_t     shift;
      align_dir_e dir;
      logic       sign_ab;
      logic       sign_eff_c;
   } unpack_s;

   typedef struct packed {
      prod_t       product;
      ext_addend_t addend;
      add_mode_e   mode;
      align_dir_e  dir;
      exp_t        current_exp;
      exp_t        exp_c;
      logic        sign_ab;
      logic        sign_eff_c;
   } mult_s;

   typedef struct packed {
      logic [39:0] sum_lo;
      logic        carry;
      logic [7:0]  prod_hi;
      logic [35:0] addend_hi;
      add_mode_e   mode;
      align_dir_e  dir;
      exp_t        current_exp;
      exp_t        exp_c;
      logic        sign_ab;
   } add_s;

   typedef struct packed {
      norm_t      window;
      sshift_t    shift_left;
      sshift_t    real_shift;
      exp_t       current_exp;
      exp_t       exp_c;
      logic       sign;
      add_mode_e  mode;
      align_dir_e dir;
   } norm_s;

   // 38 when no bit is set
   function automatic lz_t lz_count(norm_t x);
      lz_t  n;
      logic found;
      n = lz_t'(38);
      found = 1'b0;
      for (int i = 37; i >= 0; i--) begin
         if (!found && x[i]) begin
            n = lz_t'(37 - i);
            found = 1'b1;
         end
      end
      return n;
   endfunction

endpackage
